// ==== Makefile ====
VERILATOR ?= verilator
TOP       := dbus_soc_tb
RTL_TOP   := dbus_soc
FILELIST  := tb.f
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps -Wall
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/bus_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  soc_bus_pkg::bus_req_t cpu_req_i,
    input  soc_bus_pkg::bus_req_t dma_req_i,
    output soc_bus_pkg::grant_t   grant_o,
    output soc_bus_pkg::bus_req_t bus_req_o
);
    import soc_bus_pkg::*;

    logic   cpu_pend;
    logic   dma_pend;
    logic   prio_q;
    grant_t grant;

    assign cpu_pend = cpu_req_i.read | cpu_req_i.write;
    assign dma_pend = dma_req_i.read | dma_req_i.write;

    // Priority bit only matters when both masters ask
    always_comb begin
        grant = '0;
        if (cpu_pend && dma_pend) begin
            if (prio_q) begin
                grant[GRANT_DMA] = 1'b1;
            end else begin
                grant[GRANT_CPU] = 1'b1;
            end
        end else if (cpu_pend) begin
            grant[GRANT_CPU] = 1'b1;
        end else if (dma_pend) begin
            grant[GRANT_DMA] = 1'b1;
        end
    end

    always_comb begin
        bus_req_o = '0;
        if (grant[GRANT_CPU]) begin
            bus_req_o = cpu_req_i;
        end else if (grant[GRANT_DMA]) begin
            bus_req_o = dma_req_i;
        end
    end

    // Hand priority to the loser after a contended grant
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q <= 1'b0;
        end else if (cpu_pend && dma_pend) begin
            prio_q <= grant[GRANT_CPU];
        end
    end

    assign grant_o = grant;

endmodule

`default_nettype wire

// ==== design/bus_flash.sv ====
`default_nettype none
`timescale 1ns/1ps

module bus_flash (
    input  logic                    clk_i,
    input  soc_bus_pkg::slave_req_t req_i,
    output soc_bus_pkg::bus_data_t  rdata_o
);
    import soc_bus_pkg::*;
    import periph_pkg::*;

    bus_data_t              mem [FLASH_WORDS];
    logic [FLASH_IDX_W-1:0] idx;

    assign idx = req_i.addr[FLASH_IDX_W+1:2];

    // Erased array
    initial begin
        for (int i = 0; i < FLASH_WORDS; i++) begin
            mem[i] = '1;
        end
    end

    // Programming can only pull bits low
    always_ff @(posedge clk_i) begin
        if (req_i.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.byteenable[b]) begin
                    mem[idx][b*8 +: 8] <= mem[idx][b*8 +: 8] & req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    assign rdata_o = req_i.rd ? mem[idx] : '0;

endmodule

`default_nettype wire

// ==== design/bus_gpio.sv ====
`default_nettype none
`timescale 1ns/1ps

module bus_gpio (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  soc_bus_pkg::slave_req_t req_i,
    output soc_bus_pkg::bus_data_t  rdata_o,
    input  logic [31:0]             gpio_i,
    output logic [31:0]             gpio_o
);
    import soc_bus_pkg::*;
    import periph_pkg::*;

    bus_data_t out_q;
    bus_data_t in_meta_q;
    bus_data_t in_sync_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q     <= '0;
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_i;
            in_sync_q <= in_meta_q;
            if (req_i.wr && (req_i.addr[7:0] == GPIO_OUT_OFS)) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.byteenable[b]) begin
                        out_q[b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign gpio_o = out_q;

    always_comb begin
        rdata_o = '0;
        if (req_i.rd) begin
            case (req_i.addr[7:0])
                GPIO_OUT_OFS: rdata_o = out_q;
                GPIO_IN_OFS:  rdata_o = in_sync_q;
                default:      rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/bus_ram.sv ====
`default_nettype none
`timescale 1ns/1ps

module bus_ram (
    input  logic                    clk_i,
    input  soc_bus_pkg::slave_req_t req_i,
    output soc_bus_pkg::bus_data_t  rdata_o
);
    import soc_bus_pkg::*;
    import periph_pkg::*;

    bus_data_t            mem [RAM_WORDS];
    logic [RAM_IDX_W-1:0] idx;

    // Word index wraps on the upper address bits
    assign idx = req_i.addr[RAM_IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        if (req_i.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.byteenable[b]) begin
                    mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    assign rdata_o = req_i.rd ? mem[idx] : '0;

endmodule

`default_nettype wire

// ==== design/bus_uart.sv ====
`default_nettype none
`timescale 1ns/1ps

module bus_uart (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  soc_bus_pkg::slave_req_t req_i,
    output soc_bus_pkg::bus_data_t  rdata_o,
    output logic                    tx_o
);
    import soc_bus_pkg::*;
    import periph_pkg::*;

    logic                       busy_q;
    logic [UART_FRAME_BITS-1:0] shift_q;
    logic [UART_DIV_W-1:0]      div_q;
    logic [UART_BIT_W-1:0]      bit_q;
    logic                       start;
    logic                       bit_end;

    assign start   = req_i.wr && (req_i.addr[3:0] == UART_TXDATA_OFS) && !busy_q;
    assign bit_end = (div_q == UART_DIV_W'(UART_CLKS_PER_BIT - 1));

    // ========================================================
    // Transmit shifter
    // ========================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            shift_q <= '1;
            div_q   <= '0;
            bit_q   <= '0;
        end else if (start) begin
            // Stop, data LSB first, start in bit 0
            busy_q  <= 1'b1;
            shift_q <= {1'b1, req_i.wdata[7:0], 1'b0};
            div_q   <= '0;
            bit_q   <= '0;
        end else if (busy_q) begin
            if (bit_end) begin
                div_q   <= '0;
                shift_q <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
                if (bit_q == UART_BIT_W'(UART_FRAME_BITS - 1)) begin
                    busy_q <= 1'b0;
                    bit_q  <= '0;
                end else begin
                    bit_q <= bit_q + 1'b1;
                end
            end else begin
                div_q <= div_q + 1'b1;
            end
        end
    end

    // Idle shifter is all ones, so the line rests high
    assign tx_o = shift_q[0];

    always_comb begin
        rdata_o = '0;
        if (req_i.rd && (req_i.addr[3:0] == UART_STATUS_OFS)) begin
            rdata_o[0] = busy_q;
        end
    end

endmodule

`default_nettype wire

// ==== design/dbus.sv ====
`default_nettype none
`timescale 1ns/1ps

module dbus (
    input  soc_bus_pkg::bus_req_t   bus_req_i,
    output soc_bus_pkg::bus_data_t  rddata_o,
    output soc_bus_pkg::slave_req_t ram_req_o,
    output soc_bus_pkg::slave_req_t flash_req_o,
    output soc_bus_pkg::slave_req_t uart_req_o,
    output soc_bus_pkg::slave_req_t gpio_req_o,
    input  soc_bus_pkg::bus_data_t  ram_rdata_i,
    input  soc_bus_pkg::bus_data_t  flash_rdata_i,
    input  soc_bus_pkg::bus_data_t  uart_rdata_i,
    input  soc_bus_pkg::bus_data_t  gpio_rdata_i
);
    import soc_bus_pkg::*;

    slave_req_t common_req;

    // Shared payload without strobes
    always_comb begin
        common_req            = '0;
        common_req.addr       = bus_req_i.addr[23:0];
        common_req.byteenable = bus_req_i.byteenable;
        common_req.wdata      = bus_req_i.wdata;
    end

    // ========================================================
    // Address decode
    // ========================================================

    always_comb begin
        ram_req_o   = common_req;
        flash_req_o = common_req;
        uart_req_o  = common_req;
        gpio_req_o  = common_req;
        rddata_o    = '0;

        if (bus_req_i.addr[31:24] == RAM_BASE_HI) begin
            ram_req_o.rd = bus_req_i.read;
            ram_req_o.wr = bus_req_i.write;
            rddata_o     = ram_rdata_i;
        end else if (bus_req_i.addr[31:24] == FLASH_BASE_HI) begin
            flash_req_o.rd = bus_req_i.read;
            flash_req_o.wr = bus_req_i.write;
            rddata_o       = flash_rdata_i;
        end else if (bus_req_i.addr[31:4] == UART_BASE) begin
            uart_req_o.rd = bus_req_i.read;
            uart_req_o.wr = bus_req_i.write;
            rddata_o      = uart_rdata_i;
        end else if (bus_req_i.addr[31:8] == GPIO_BASE) begin
            gpio_req_o.rd = bus_req_i.read;
            gpio_req_o.wr = bus_req_i.write;
            rddata_o      = gpio_rdata_i;
        end
        // unmapped addresses get no strobes and read zero
    end

endmodule

`default_nettype wire

// ==== design/dbus_soc.sv ====
`default_nettype none
`timescale 1ns/1ps

module dbus_soc (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  soc_bus_pkg::bus_req_t  cpu_req_i,
    input  soc_bus_pkg::bus_req_t  dma_req_i,
    output soc_bus_pkg::grant_t    grant_o,
    output soc_bus_pkg::bus_data_t rddata_o,
    output logic                   tx_o,
    input  logic [31:0]            gpio_i,
    output logic [31:0]            gpio_o
);
    import soc_bus_pkg::*;

    bus_req_t   bus_req;
    slave_req_t ram_req;
    slave_req_t flash_req;
    slave_req_t uart_req;
    slave_req_t gpio_req;
    bus_data_t  ram_rdata;
    bus_data_t  flash_rdata;
    bus_data_t  uart_rdata;
    bus_data_t  gpio_rdata;

    // ========================================================
    // Arbitration and decode
    // ========================================================

    bus_arbiter u_arbiter (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .cpu_req_i (cpu_req_i),
        .dma_req_i (dma_req_i),
        .grant_o   (grant_o),
        .bus_req_o (bus_req)
    );

    dbus u_dbus (
        .bus_req_i     (bus_req),
        .rddata_o      (rddata_o),
        .ram_req_o     (ram_req),
        .flash_req_o   (flash_req),
        .uart_req_o    (uart_req),
        .gpio_req_o    (gpio_req),
        .ram_rdata_i   (ram_rdata),
        .flash_rdata_i (flash_rdata),
        .uart_rdata_i  (uart_rdata),
        .gpio_rdata_i  (gpio_rdata)
    );

    // ========================================================
    // Slaves
    // ========================================================

    bus_ram u_ram (
        .clk_i   (clk_i),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

    bus_flash u_flash (
        .clk_i   (clk_i),
        .req_i   (flash_req),
        .rdata_o (flash_rdata)
    );

    bus_uart u_uart (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (uart_req),
        .rdata_o (uart_rdata),
        .tx_o    (tx_o)
    );

    bus_gpio u_gpio (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (gpio_req),
        .rdata_o (gpio_rdata),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o)
    );

endmodule

`default_nettype wire

// ==== design/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    // Memory depths in 32-bit words
    localparam int RAM_WORDS   = 1024;
    localparam int FLASH_WORDS = 256;

    localparam int RAM_IDX_W   = $clog2(RAM_WORDS);
    localparam int FLASH_IDX_W = $clog2(FLASH_WORDS);

    // UART bit timing
    localparam int UART_CLKS_PER_BIT = 4;
    localparam int UART_DIV_W        = $clog2(UART_CLKS_PER_BIT);
    localparam int UART_FRAME_BITS   = 10;
    localparam int UART_BIT_W        = $clog2(UART_FRAME_BITS);

    // Register offsets
    localparam logic [3:0] UART_TXDATA_OFS = 4'h0;
    localparam logic [3:0] UART_STATUS_OFS = 4'h4;

    localparam logic [7:0] GPIO_OUT_OFS = 8'h00;
    localparam logic [7:0] GPIO_IN_OFS  = 8'h04;

endpackage

`default_nettype wire

// ==== design/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    // ========================================================
    // Bus types
    // ========================================================

    typedef logic [31:0] bus_data_t;

    // Request as driven by one master
    typedef struct packed {
        logic      read;
        logic      write;
        logic [31:0] addr;
        logic [3:0]  byteenable;
        bus_data_t   wdata;
    } bus_req_t;

    // Request as seen by one slave with the low address bits only
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [23:0] addr;
        logic [3:0]  byteenable;
        bus_data_t   wdata;
    } slave_req_t;

    // One-hot grant with bit 0 for the CPU and bit 1 for DMA
    typedef logic [1:0] grant_t;

    localparam int GRANT_CPU = 0;
    localparam int GRANT_DMA = 1;

    // ========================================================
    // Address map
    // ========================================================

    localparam logic [7:0]  RAM_BASE_HI   = 8'h00;
    localparam logic [7:0]  FLASH_BASE_HI = 8'h1E;
    localparam logic [27:0] UART_BASE     = 28'h1FD003F;
    localparam logic [23:0] GPIO_BASE     = 24'h1FD004;

endpackage

`default_nettype wire

// ==== sim/dbus_soc_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module dbus_soc_tb;
    import soc_bus_pkg::*;
    import periph_pkg::*;

    localparam int         CLK_PERIOD       = 40;
    localparam int         RESET_CYCLES     = 10;
    localparam int         CYCLES_PER_OP    = 60;
    localparam int         GRANT_WAIT_LIMIT = 20;
    localparam int         FRAME_WAIT_LIMIT = 100;
    localparam logic [7:0] UNMAPPED_HI      = 8'hFF;
    localparam string      TEST_FILE        = "sim/dbus_testdata.txt";

    // One line of the data file
    typedef struct packed {
        logic [7:0]  op;
        logic        master;
        logic [31:0] addr;
        logic [3:0]  be;
        bus_data_t   data;
        bus_data_t   exp;
        logic [15:0] line_no;
    } test_op_t;

    logic        clk;
    logic        rst_n;
    bus_req_t    cpu_req;
    bus_req_t    dma_req;
    grant_t      grant;
    bus_data_t   rddata;
    logic        tx;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;

    test_op_t    ops[$];
    logic [7:0]  rx_q[$];
    logic        rx_busy = 1'b0;
    int          n_ops = 0;
    int          data_errors = 0;
    int          grant_errors = 0;
    int          bit_errors = 0;
    int          other_errors = 0;

    dbus_soc dbus_soc_i (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .cpu_req_i (cpu_req),
        .dma_req_i (dma_req),
        .grant_o   (grant),
        .rddata_o  (rddata),
        .tx_o      (tx),
        .gpio_i    (gpio_in),
        .gpio_o    (gpio_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ========================================================
    // Compare tasks
    // ========================================================

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %08h, actual %08h", name, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_grant(input string name, input grant_t exp, input grant_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            grant_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            bit_errors++;
        end
    endtask

    // ========================================================
    // Operations
    // ========================================================

    task automatic drive_master(input logic master, input bus_req_t req);
        if (master) begin
            dma_req <= req;
        end else begin
            cpu_req <= req;
        end
    endtask

    // Lone request that should win in the cycle it is presented
    task automatic bus_transfer(input test_op_t t, input logic is_read);
        bus_req_t req;
        grant_t   want;
        int       waited;
        string    name;
        req            = '0;
        req.read       = is_read;
        req.write      = !is_read;
        req.addr       = t.addr;
        req.byteenable = t.be;
        req.wdata      = is_read ? '0 : t.data;
        want           = t.master ? 2'b10 : 2'b01;
        name           = $sformatf("line %0d %s", t.line_no, is_read ? "read" : "write");
        @(posedge clk);
        drive_master(t.master, req);
        @(negedge clk);
        check_grant({name, " grant"}, want, grant);
        waited = 0;
        while ((grant & want) == '0 && waited < GRANT_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if ((grant & want) == '0) begin
            $display("ERROR: %s was never granted", name);
            other_errors++;
        end else if (is_read) begin
            check_data({name, " data"}, t.exp, rddata);
        end
        @(posedge clk);
        drive_master(t.master, '0);
    endtask

    // Winner reads the line's address while the loser reads an unmapped one
    task automatic contend(input test_op_t t);
        bus_req_t win_req;
        bus_req_t lose_req;
        grant_t   win;
        string    name;
        win_req            = '0;
        win_req.read       = 1'b1;
        win_req.addr       = t.addr;
        win_req.byteenable = t.be;
        lose_req           = win_req;
        lose_req.addr      = {UNMAPPED_HI, t.addr[23:0]};
        win                = t.master ? 2'b10 : 2'b01;
        name               = $sformatf("line %0d contention", t.line_no);
        @(posedge clk);
        drive_master(t.master, win_req);
        drive_master(!t.master, lose_req);
        @(negedge clk);
        check_grant({name, " first grant"}, win, grant);
        check_data({name, " first data"}, t.exp, rddata);
        @(posedge clk);
        drive_master(t.master, '0);
        @(negedge clk);
        check_grant({name, " second grant"}, ~win, grant);
        check_data({name, " second data"}, '0, rddata);
        @(posedge clk);
        drive_master(!t.master, '0);
    endtask

    task automatic drive_gpio(input test_op_t t);
        @(posedge clk);
        gpio_in <= t.data;
        @(negedge clk);
        check_data($sformatf("line %0d gpio_o", t.line_no), t.exp, gpio_out);
        @(posedge clk);
    endtask

    task automatic expect_frame(input test_op_t t);
        int         waited;
        logic [7:0] got;
        waited = 0;
        while (rx_q.size() == 0 && waited < FRAME_WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (rx_q.size() == 0) begin
            $display("ERROR: line %0d saw no UART frame on tx_o", t.line_no);
            other_errors++;
        end else begin
            got = rx_q.pop_front();
            check_data($sformatf("line %0d uart byte", t.line_no), t.exp, {24'h0, got});
        end
    endtask

    task automatic run_op(input test_op_t t);
        case (t.op)
            "W": bus_transfer(t, 1'b0);
            "R": bus_transfer(t, 1'b1);
            "C": contend(t);
            "G": drive_gpio(t);
            "U": expect_frame(t);
            default: begin
                $display("ERROR: line %0d has unknown operation %c", t.line_no, t.op);
                other_errors++;
            end
        endcase
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        int          lineno;
        int          m;
        byte         op_c;
        logic [31:0] addr;
        logic [3:0]  be;
        bus_data_t   data;
        bus_data_t   exp;
        string       line;
        test_op_t    t;
        lineno = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open %s", TEST_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            lineno++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %d %h %h %h %h", op_c, m, addr, be, data, exp);
            if (n != 6) begin
                $display("ERROR: line %0d of %s could not be parsed", lineno, TEST_FILE);
                other_errors++;
            end else begin
                t.op      = op_c;
                t.master  = m[0];
                t.addr    = addr;
                t.be      = be;
                t.data    = data;
                t.exp     = exp;
                t.line_no = 16'(lineno);
                ops.push_back(t);
            end
        end
        $fclose(fd);
        n_ops = ops.size();
    endtask

    // ========================================================
    // Serial receiver on tx_o sampling mid-bit
    // ========================================================

    initial begin : uart_receiver
        logic [7:0] rx_byte;
        rx_byte = '0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                rx_busy = 1'b1;
                repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
                check_bit("uart start bit", 1'b0, tx);
                for (int i = 0; i < 8; i++) begin
                    repeat (UART_CLKS_PER_BIT) @(negedge clk);
                    rx_byte[i] = tx;
                end
                repeat (UART_CLKS_PER_BIT) @(negedge clk);
                check_bit("uart stop bit", 1'b1, tx);
                repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
                rx_q.push_back(rx_byte);
                rx_busy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (n_ops > 0);
        #(n_ops * CYCLES_PER_OP * CLK_PERIOD);
        $display("ERROR: timeout, tests did not finish within %0d cycles", n_ops * CYCLES_PER_OP);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        cpu_req = '0;
        dma_req = '0;
        gpio_in = '0;
        load_tests();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_grant("reset grant", 2'b00, grant);
        check_bit("reset tx_o", 1'b1, tx);
        check_data("reset gpio_o", '0, gpio_out);

        if (ops.size() == 0) begin
            $display("ERROR: no test lines were loaded");
            other_errors++;
        end
        foreach (ops[i]) begin
            run_op(ops[i]);
        end

        // Dropped UART writes must not leave a frame behind
        repeat (CYCLES_PER_OP) @(posedge clk);
        if (rx_q.size() != 0 || rx_busy) begin
            $display("ERROR: an unexpected UART frame appeared after the last test");
            other_errors++;
        end

        $display("Error counts: data %0d, grant %0d, bit %0d, other %0d",
                 data_errors, grant_errors, bit_errors, other_errors);
        if (data_errors + grant_errors + bit_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/dbus_testdata.txt ====
# op master addr be data expected, all hex except master (0 CPU, 1 DMA)
# W write, R read and compare, C both read (master wins first), G gpio_i and gpio_o, U uart byte
R 0 1FD003F4 f 00000000 00000000
W 0 00000010 f 11223344 00000000
W 1 00000010 3 0000aabb 00000000
R 1 00000010 f 00000000 1122aabb
W 1 00000014 f 55555555 00000000
W 0 00000014 c 99880000 00000000
R 1 00000014 f 00000000 99885555
W 1 00000014 4 00770000 00000000
R 0 00000014 f 00000000 99775555
R 0 1E000020 f 00000000 ffffffff
W 0 1E000020 f 0f0ff0f0 00000000
R 1 1E000020 f 00000000 0f0ff0f0
W 1 1E000020 3 ffff00ff 00000000
R 0 1E000020 f 00000000 0f0f00f0
W 0 1E000020 f ffffffff 00000000
R 0 1E000020 f 00000000 0f0f00f0
R 1 1E0003FC f 00000000 ffffffff
C 0 00000010 f 00000000 1122aabb
C 1 00000014 f 00000000 99775555
C 0 1E000020 f 00000000 0f0f00f0
C 1 00000010 f 00000000 1122aabb
W 0 1FD003F0 1 000000a5 00000000
R 1 1FD003F4 f 00000000 00000001
W 1 1FD003F0 1 0000003c 00000000
R 0 1FD003F0 f 00000000 00000000
U 0 00000000 0 00000000 000000a5
R 0 1FD003F4 f 00000000 00000000
W 1 1FD003F0 1 0000005a 00000000
U 1 00000000 0 00000000 0000005a
W 0 1FD00400 f 12345678 00000000
R 1 1FD00400 f 00000000 12345678
W 1 1FD00400 2 0000ab00 00000000
R 0 1FD00400 f 00000000 1234ab78
G 0 00000000 0 cafef00d 1234ab78
R 0 1FD00404 f 00000000 cafef00d
G 0 00000000 0 0f0f0f0f 1234ab78
R 1 1FD00404 f 00000000 0f0f0f0f
R 0 20000000 f 00000000 00000000
W 0 01000010 f deadbeef 00000000
R 0 01000010 f 00000000 00000000
R 1 00000010 f 00000000 1122aabb
W 1 1FD00500 f ffffffff 00000000
R 1 1FD00500 f 00000000 00000000
R 0 1FD00400 f 00000000 1234ab78
W 0 1F000020 f 00000000 00000000
R 0 1E000020 f 00000000 0f0f00f0

// ==== tb.f ====
design/soc_bus_pkg.sv
design/periph_pkg.sv
design/bus_arbiter.sv
design/dbus.sv
design/bus_ram.sv
design/bus_flash.sv
design/bus_uart.sv
design/bus_gpio.sv
design/dbus_soc.sv
sim/dbus_soc_tb.sv
